/* Makefile */
VERILATOR  ?= verilator
FILELIST   := verilog.f
TB_TOP     := tb_cpu_execute
RTL_TOP    := cpu_execute_top
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing -j 0 -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q '^NO ERRORS$$' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/cpu_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_alu
  import cpu_pkg::*;
(
  input  logic [WORD_W-1:0] i_a,
  input  logic [WORD_W-1:0] i_b,
  input  logic              i_sub,
  output logic [WORD_W-1:0] o_r,
  output logic              o_n,
  output logic              o_z
);

  logic [WORD_W-1:0] b_eff;

  // a - b as a + ~b + 1, one adder for both
  assign b_eff = i_b ^ {WORD_W{i_sub}};
  assign o_r   = i_a + b_eff + {{(WORD_W-1){1'b0}}, i_sub};

  assign o_n = o_r[WORD_W-1]; // sign bit
  assign o_z = ~|o_r;

endmodule

`default_nettype wire

/* logic/cpu_data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_data_ram
  import cpu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rd,
  input  logic              i_wr,
  input  logic [MEM_AW-1:0] i_addr,
  input  logic [WORD_W-1:0] i_wrdata,
  output logic [WORD_W-1:0] o_rddata
);

  logic [WORD_W-1:0] mem [0:(1<<MEM_AW)-1];

  always_ff @(posedge i_clk) begin
    if (i_wr) mem[i_addr] <= i_wrdata;
    // registered read, output holds between loads
    if (i_rd) o_rddata <= mem[i_addr];
  end

endmodule

`default_nettype wire

/* logic/cpu_execute_control.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_execute_control
  import cpu_pkg::*;
(
  input  logic     i_clk,   // kept for interface compatibility, decode is comb
  input  logic     i_rst_n,
  input  instr_u   i_ir_ex,
  input  instr_u   i_ir_wr,
  input  logic     i_fw_rx,
  input  logic     i_fw_ry,
  output ex_ctrl_t o_ctrl
);

  logic [4:0] op_ex;
  logic       imm_form;
  logic       is_alu;  // add, sub, cmp and imm forms
  logic       is_mem;  // ld, st
  logic       is_mv;   // register mv only, mvi needs no operand
  logic       is_mvhi;
  logic       ex_nop;
  logic       wr_nop;

  assign op_ex    = i_ir_ex.r.op;
  assign imm_form = op_ex[4];

  // classes decoded on the low four bits, like the isa table
  assign is_alu  = (op_ex[3:0] == OP_ADD[3:0]) ||
                   (op_ex[3:0] == OP_SUB[3:0]) ||
                   (op_ex[3:0] == OP_CMP[3:0]);
  assign is_mem  = (op_ex[3:0] == OP_LD[3:0]) || (op_ex[3:0] == OP_ST[3:0]);
  assign is_mv   = (op_ex == OP_MV);
  assign is_mvhi = (op_ex[3:0] == OP_MVHI[3:0]);
  assign ex_nop  = (op_ex[3:0] == OP_NOP[3:0]);
  assign wr_nop  = (i_ir_wr.r.op == OP_NOP); // only right after reset

  always_comb begin
    o_ctrl          = '0;
    o_ctrl.pc_wr_ld = 1'b1; // advance every cycle by default
    o_ctrl.ir_wr_ld = 1'b1;

    // data regs hold while wb slot is empty or a nop stalls ex
    o_ctrl.datax_wr_ld = ~wr_nop & ~ex_nop;
    o_ctrl.datay_wr_ld = ~wr_nop & ~ex_nop;

    if (is_mv) begin
      o_ctrl.datay_wr_sel = i_fw_ry; // mv rx, ry
    end

    if (is_mvhi) begin
      o_ctrl.datax_wr_sel = i_fw_rx; // low byte of rx kept
    end

    if (is_alu) begin
      o_ctrl.alu_r_ld   = 1'b1;
      o_ctrl.alu_n_ld   = 1'b1;
      o_ctrl.alu_z_ld   = 1'b1;
      o_ctrl.alu_op_sel = op_ex[1]; // sub and cmp subtract
      o_ctrl.alu_a_sel  = i_fw_rx ? 2'd0 : 2'd1;
      if (imm_form)     o_ctrl.alu_b_sel = 2'd1; // ry field is imm bits here
      else if (i_fw_ry) o_ctrl.alu_b_sel = 2'd0;
      else              o_ctrl.alu_b_sel = 2'd2;
    end

    if (is_mem) begin
      o_ctrl.ldst_rd         = ~op_ex[0]; // ld
      o_ctrl.ldst_wr         = op_ex[0];  // st
      o_ctrl.ldst_wrdata_sel = i_fw_rx;   // st data is rx
      o_ctrl.ldst_addr_sel   = i_fw_ry;   // address is ry
    end

    // nop freezes the wb stage
    if (ex_nop) begin
      o_ctrl.pc_wr_ld = 1'b0;
      o_ctrl.ir_wr_ld = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* logic/cpu_execute_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_execute_datapath
  import cpu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  instr_u            i_ir,
  input  logic [WORD_W-1:0] i_pc,
  input  ex_ctrl_t          i_ctrl,
  input  logic [WORD_W-1:0] i_rx_data,
  input  logic [WORD_W-1:0] i_ry_data,
  output instr_u            o_ir_wr,
  output logic [MEM_AW-1:0] o_mem_addr,
  output logic [WORD_W-1:0] o_mem_wrdata,
  output logic              o_mem_rd,
  output logic              o_mem_wr,
  input  logic [WORD_W-1:0] i_mem_rddata,
  output wb_t               o_wb,
  output logic              o_alu_n,
  output logic              o_alu_z
);

  logic [WORD_W-1:0] fwd;       // value being written back now
  logic [WORD_W-1:0] imm_ex;    // sign extended imm8 of ex instr
  logic [WORD_W-1:0] imm_wr;    // same for the wb instr
  logic [WORD_W-1:0] alu_a;
  logic [WORD_W-1:0] alu_b;
  logic [WORD_W-1:0] alu_res;
  logic              alu_n_nxt;
  logic              alu_z_nxt;
  logic [WORD_W-1:0] datax_nxt;
  logic [WORD_W-1:0] datay_nxt;

  // wb stage registers
  logic [WORD_W-1:0] alu_r;
  logic [WORD_W-1:0] pc_wr;
  instr_u            ir_wr;
  logic [WORD_W-1:0] datax_wr;
  logic [WORD_W-1:0] datay_wr;

  assign fwd    = o_wb.data;
  assign imm_ex = {{(WORD_W-8){i_ir.i.imm8[7]}}, i_ir.i.imm8};
  assign imm_wr = {{(WORD_W-8){ir_wr.i.imm8[7]}}, ir_wr.i.imm8};

  // operand muxes
  assign alu_a = (i_ctrl.alu_a_sel == 2'd0) ? fwd : i_rx_data;

  always_comb begin
    case (i_ctrl.alu_b_sel)
      2'd0:    alu_b = fwd;
      2'd1:    alu_b = imm_ex;
      default: alu_b = i_ry_data;
    endcase
  end

  cpu_alu u_cpu_alu (
    .i_a   (alu_a),
    .i_b   (alu_b),
    .i_sub (i_ctrl.alu_op_sel),
    .o_r   (alu_res),
    .o_n   (alu_n_nxt),
    .o_z   (alu_z_nxt)
  );

  assign datax_nxt = i_ctrl.datax_wr_sel ? fwd : i_rx_data; // mvhi low byte
  assign datay_nxt = i_ctrl.datay_wr_sel ? fwd : i_ry_data; // mv source

  // ram port, address is ry and data is rx
  assign o_mem_addr   = i_ctrl.ldst_addr_sel ? fwd[MEM_AW-1:0] : i_ry_data[MEM_AW-1:0];
  assign o_mem_wrdata = i_ctrl.ldst_wrdata_sel ? fwd : i_rx_data;
  assign o_mem_rd     = i_ctrl.ldst_rd;
  assign o_mem_wr     = i_ctrl.ldst_wr;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_wr    <= '0;
      ir_wr    <= {{(WORD_W-5){1'b0}}, OP_NOP}; // empty wb slot
      datax_wr <= '0;     // matches the cleared regfile
      datay_wr <= '0;
      o_alu_n  <= 1'b0;
      o_alu_z  <= 1'b0;
    end else begin
      if (i_ctrl.pc_wr_ld)    pc_wr    <= i_pc;
      if (i_ctrl.ir_wr_ld)    ir_wr    <= i_ir;
      if (i_ctrl.datax_wr_ld) datax_wr <= datax_nxt;
      if (i_ctrl.datay_wr_ld) datay_wr <= datay_nxt;
      if (i_ctrl.alu_n_ld)    o_alu_n  <= alu_n_nxt;
      if (i_ctrl.alu_z_ld)    o_alu_z  <= alu_z_nxt;
    end
  end

  // only read when ir_wr is an alu op
  always_ff @(posedge i_clk) begin
    if (i_ctrl.alu_r_ld) alu_r <= alu_res;
  end

  // wb result select, writers only raise en
  always_comb begin
    o_wb.en   = 1'b1;
    o_wb.addr = ir_wr.r.rx;
    o_wb.pc   = pc_wr;
    case (ir_wr.r.op)
      OP_MV:            o_wb.data = datay_wr;
      OP_MV  | OP_IMM:  o_wb.data = imm_wr;  // mvi
      OP_ADD,
      OP_ADD | OP_IMM,
      OP_SUB,
      OP_SUB | OP_IMM:  o_wb.data = alu_r;
      OP_LD:            o_wb.data = i_mem_rddata; // ram read lands here
      OP_MVHI:          o_wb.data = {ir_wr.i.imm8, datax_wr[7:0]};
      default: begin                       // cmp, st, nop, jumps
        o_wb.en   = 1'b0;
        o_wb.data = '0;
      end
    endcase
  end

  assign o_ir_wr = ir_wr;

endmodule

`default_nettype wire

/* logic/cpu_execute_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_execute_top
  import cpu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  instr_u            i_ir,
  input  logic [WORD_W-1:0] i_pc,
  output wb_t               o_wb,
  output logic              o_alu_n,
  output logic              o_alu_z
);

  ex_ctrl_t          ctrl;
  instr_u            ir_wr;     // instr in the wb stage
  wb_t               wb;
  logic              fw_rx;
  logic              fw_ry;
  logic [WORD_W-1:0] rx_data;
  logic [WORD_W-1:0] ry_data;
  logic [MEM_AW-1:0] mem_addr;
  logic [WORD_W-1:0] mem_wrdata;
  logic [WORD_W-1:0] mem_rddata;
  logic              mem_rd;
  logic              mem_wr;

  cpu_execute_control u_cpu_execute_control (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ir_ex (i_ir),
    .i_ir_wr (ir_wr),
    .i_fw_rx (fw_rx),
    .i_fw_ry (fw_ry),
    .o_ctrl  (ctrl)
  );

  cpu_forward_detect u_cpu_forward_detect (
    .i_ir_ex (i_ir),
    .i_wb    (wb),
    .o_fw_rx (fw_rx),
    .o_fw_ry (fw_ry)
  );

  cpu_execute_datapath u_cpu_execute_datapath (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_ir         (i_ir),
    .i_pc         (i_pc),
    .i_ctrl       (ctrl),
    .i_rx_data    (rx_data),
    .i_ry_data    (ry_data),
    .o_ir_wr      (ir_wr),
    .o_mem_addr   (mem_addr),
    .o_mem_wrdata (mem_wrdata),
    .o_mem_rd     (mem_rd),
    .o_mem_wr     (mem_wr),
    .i_mem_rddata (mem_rddata),
    .o_wb         (wb),
    .o_alu_n      (o_alu_n),
    .o_alu_z      (o_alu_z)
  );

  cpu_regfile u_cpu_regfile (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_rx      (i_ir.r.rx),
    .i_ry      (i_ir.r.ry),
    .o_rx_data (rx_data),
    .o_ry_data (ry_data),
    .i_wb      (wb)
  );

  cpu_data_ram u_cpu_data_ram (
    .i_clk    (i_clk),
    .i_rd     (mem_rd),
    .i_wr     (mem_wr),
    .i_addr   (mem_addr),
    .i_wrdata (mem_wrdata),
    .o_rddata (mem_rddata)
  );

  assign o_wb = wb;

endmodule

`default_nettype wire

/* logic/cpu_forward_detect.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_forward_detect
  import cpu_pkg::*;
(
  input  instr_u i_ir_ex,
  input  wb_t    i_wb,
  output logic   o_fw_rx,
  output logic   o_fw_ry
);

  logic rx_hit;
  logic ry_hit;

  // raw against the single pending write
  assign rx_hit = (i_wb.addr == i_ir_ex.r.rx);
  assign ry_hit = (i_wb.addr == i_ir_ex.r.ry); // raw field, control filters imm forms

  // no write pending means nothing to forward
  assign o_fw_rx = i_wb.en & rx_hit;
  assign o_fw_ry = i_wb.en & ry_hit;

endmodule

`default_nettype wire

/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int WORD_W = 16; // data and instruction width
  localparam int REG_AW = 3;  // 8 registers
  localparam int MEM_AW = 8;  // 256 word data ram

  // 5 bit opcodes, bit 4 selects the immediate form
  localparam logic [4:0] OP_IMM  = 5'b10000; // immediate form marker
  localparam logic [4:0] OP_MV   = 5'b00000;
  localparam logic [4:0] OP_ADD  = 5'b00001;
  localparam logic [4:0] OP_SUB  = 5'b00010;
  localparam logic [4:0] OP_CMP  = 5'b00011;
  localparam logic [4:0] OP_LD   = 5'b00100;
  localparam logic [4:0] OP_ST   = 5'b00101;
  localparam logic [4:0] OP_MVHI = 5'b10110; // only has an immediate form
  localparam logic [4:0] OP_NOP  = 5'b00111;

  typedef struct packed {
    logic [4:0]        rsvd; // unused in register form
    logic [REG_AW-1:0] ry;
    logic [REG_AW-1:0] rx;   // also the destination
    logic [4:0]        op;
  } instr_reg_t;

  typedef struct packed {
    logic [7:0]        imm8;
    logic [REG_AW-1:0] rx;
    logic [4:0]        op;
  } instr_imm_t;

  // same word, two field layouts
  typedef union packed {
    instr_reg_t r;
    instr_imm_t i;
  } instr_u;

  typedef struct packed {
    logic       pc_wr_ld;
    logic       ir_wr_ld;
    logic       alu_r_ld;
    logic       alu_n_ld;
    logic       alu_z_ld;
    logic [1:0] alu_a_sel;       // 0 fwd, 1 rx
    logic [1:0] alu_b_sel;       // 0 fwd, 1 imm, 2 ry
    logic       alu_op_sel;      // 1 subtract
    logic       datax_wr_ld;
    logic       datay_wr_ld;
    logic       datax_wr_sel;    // 1 fwd
    logic       datay_wr_sel;    // 1 fwd
    logic       ldst_rd;
    logic       ldst_wr;
    logic       ldst_addr_sel;   // 1 fwd
    logic       ldst_wrdata_sel; // 1 fwd
  } ex_ctrl_t;

  typedef struct packed {
    logic              en;
    logic [REG_AW-1:0] addr;
    logic [WORD_W-1:0] data;
    logic [WORD_W-1:0] pc;
  } wb_t;

endpackage

`default_nettype wire

/* logic/cpu_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_regfile
  import cpu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [REG_AW-1:0] i_rx,
  input  logic [REG_AW-1:0] i_ry,
  output logic [WORD_W-1:0] o_rx_data,
  output logic [WORD_W-1:0] o_ry_data,
  input  wb_t               i_wb
);

  logic [WORD_W-1:0] regs [0:(1<<REG_AW)-1];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int k = 0; k < (1<<REG_AW); k++) begin
        regs[k] <= '0;
      end
    end else if (i_wb.en) begin
      regs[i_wb.addr] <= i_wb.data; // single write port
    end
  end

  // async reads, same cycle write seen via forwarding instead
  assign o_rx_data = regs[i_rx];
  assign o_ry_data = regs[i_ry];

endmodule

`default_nettype wire

/* test/tb_cpu_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_execute
  import cpu_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 10;
  localparam int N_ALU      = 64;
  localparam int N_RAND_ST  = 32;
  localparam int N_FWD      = 64;
  localparam int N_MIX      = 48;
  // issued words per test, parking nop included
  localparam int N_INSTR = (8 + 8 + 1) + (16 + N_ALU + 1) + (256 * 5 + N_RAND_ST * 6 + 1)
                         + (2 * N_FWD + 1) + (2 * N_MIX + 1);
  localparam int WATCH_CYCLES = N_INSTR + RST_CYCLES + 20;
  localparam logic [WORD_W-1:0] NOP_WORD = {11'd0, OP_NOP};

  typedef struct packed {
    wb_t  wb;
    logic n;
    logic z;
  } expect_t;

  logic   clk = 1'b0;
  logic   rst_n;
  instr_u ir;
  logic [WORD_W-1:0] pc;
  wb_t    wb;
  logic   alu_n;
  logic   alu_z;

  // isa model state, no pipeline inside
  logic [WORD_W-1:0] ref_regs [8];
  logic [WORD_W-1:0] ref_mem  [256];
  logic              ref_n;
  logic              ref_z;
  expect_t           last_exp;   // what a nop repeats

  expect_t exp_q  [$];           // one entry per issued word
  string   name_q [$];
  int      ready_cnt = 0;        // entries already in wb at this negedge
  int      n_checks  = 0;
  int      n_errors  = 0;
  int      n_tests   = 0;
  int      test_checks0;
  int      test_errors0;
  string   test_name = "none";
  logic [WORD_W-1:0] pc_cnt;
  integer  seed = 32'he8247e0c;
  logic [7:0] st_addr [N_RAND_ST];

  always #(CLK_PERIOD / 2) clk = ~clk;

  cpu_execute_top u_cpu_execute_top (
    .i_clk   (clk),
    .i_rst_n (rst_n),
    .i_ir    (ir),
    .i_pc    (pc),
    .o_wb    (wb),
    .o_alu_n (alu_n),
    .o_alu_z (alu_z)
  );

  function automatic instr_u reg_form(input logic [4:0] op, input logic [2:0] rx,
                                      input logic [2:0] ry);
    instr_u w;
    w      = '0;
    w.r.op = op;
    w.r.rx = rx; // destination
    w.r.ry = ry;
    return w;
  endfunction

  function automatic instr_u imm_form(input logic [4:0] op, input logic [2:0] rx,
                                      input logic [7:0] imm8);
    instr_u w;
    w        = '0;
    w.i.op   = op;
    w.i.rx   = rx;
    w.i.imm8 = imm8;
    return w;
  endfunction

  // one isa step, returns the wb write and flags seen a cycle later
  function automatic expect_t ref_step(input instr_u w, input logic [WORD_W-1:0] pc_v);
    expect_t           e;
    logic [WORD_W-1:0] vx;
    logic [WORD_W-1:0] vy;
    logic [WORD_W-1:0] imm;
    logic [WORD_W-1:0] res;
    logic              writes;
    logic              sets_flags;
    if (w.r.op == OP_NOP) return last_exp; // wb stage frozen
    vx  = ref_regs[w.r.rx];
    vy  = ref_regs[w.r.ry];
    imm = {{8{w.i.imm8[7]}}, w.i.imm8}; // sign extended
    res = '0;
    case (w.r.op)
      OP_MV:           res = vy;
      OP_MV | OP_IMM:  res = imm;
      OP_ADD:          res = vx + vy;
      OP_ADD | OP_IMM: res = vx + imm;
      OP_SUB, OP_CMP:  res = vx - vy;
      OP_SUB | OP_IMM,
      OP_CMP | OP_IMM: res = vx - imm;
      OP_LD:           res = ref_mem[vy[7:0]];   // address is ry
      OP_ST:           ref_mem[vy[7:0]] = vx;    // data is rx
      OP_MVHI:         res = {w.i.imm8, vx[7:0]};
      default:         res = '0;                 // jumps do nothing
    endcase
    writes     = w.r.op inside {OP_MV, OP_MV | OP_IMM, OP_ADD, OP_ADD | OP_IMM,
                                OP_SUB, OP_SUB | OP_IMM, OP_LD, OP_MVHI};
    sets_flags = w.r.op inside {OP_ADD, OP_SUB, OP_CMP,
                                OP_ADD | OP_IMM, OP_SUB | OP_IMM, OP_CMP | OP_IMM};
    if (sets_flags) begin
      ref_n = res[WORD_W-1];
      ref_z = (res == '0);
    end
    e         = '0;
    e.wb.addr = w.r.rx;
    e.wb.pc   = pc_v;
    if (writes) begin
      e.wb.en          = 1'b1;
      e.wb.data        = res;
      ref_regs[w.r.rx] = res;
    end
    e.n      = ref_n;
    e.z      = ref_z;
    last_exp = e;
    return e;
  endfunction

  task automatic check(input string name, input logic [$bits(expect_t)-1:0] exp_v,
                       input logic [$bits(expect_t)-1:0] act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("** Error %s: expected %h, actual %h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  // word goes in at the rising edge, model runs at the same point
  task automatic issue(input instr_u word, input string mnem);
    expect_t e;
    @(posedge clk);
    ir <= word;
    pc <= pc_cnt;
    e = ref_step(word, pc_cnt);
    exp_q.push_back(e);
    name_q.push_back({test_name, "/", mnem});
    pc_cnt = pc_cnt + 16'd1;
  endtask

  task automatic load_reg(input logic [2:0] r, input logic [WORD_W-1:0] value);
    issue(imm_form(OP_MV | OP_IMM, r, value[7:0]), "mvi");
    issue(imm_form(OP_MVHI, r, value[15:8]), "mvhi");   // forwarded low byte
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    test_checks0 = n_checks;
    test_errors0 = n_errors;
  endtask

  task automatic end_test();
    issue(NOP_WORD, "park");   // stops the last word re-executing
    while (exp_q.size() != 0) @(posedge clk);
    n_tests++;
    $display("test %-9s done: %0d checks, %0d mismatches", test_name,
             n_checks - test_checks0, n_errors - test_errors0);
  endtask

  // wb of the word issued two edges back is stable here
  always @(negedge clk) begin : compare_wb
    expect_t e;
    expect_t a;
    string   nm;
    if (ready_cnt > 0) begin
      e    = exp_q.pop_front();
      nm   = name_q.pop_front();
      a.wb = wb;
      a.n  = alu_n;
      a.z  = alu_z;
      if (!e.wb.en) begin // no write, addr and data are don't care
        e.wb.addr = '0;
        e.wb.data = '0;
        a.wb.addr = '0;
        a.wb.data = '0;
      end
      check(nm, e, a);
    end
    ready_cnt = exp_q.size();
  end

  initial begin : watchdog
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("watchdog: tests still running after %0d cycles, run stopped", WATCH_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] rnd;
    logic [2:0]  rx;
    logic [2:0]  ry;
    logic [2:0]  prev_dst;
    logic [4:0]  op;
    rst_n    = 1'b0;
    ir       = NOP_WORD;
    pc       = '0;
    pc_cnt   = '0;
    ref_n    = 1'b0;
    ref_z    = 1'b0;
    last_exp = '0;
    for (int k = 0; k < 8; k++) begin
      ref_regs[k] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset_mv");
    @(negedge clk);
    check("reset_mv/state", '0, {35'd0, wb.en, alu_n, alu_z});
    for (int k = 0; k < 8; k++) begin
      rnd = $random(seed);
      issue(imm_form(OP_MV | OP_IMM, 3'(k), rnd[7:0]), "mvi");
    end
    for (int k = 0; k < 8; k++) begin
      rnd = $random(seed);
      issue(reg_form(OP_MV, 3'(k), rnd[2:0]), "mv");
    end
    end_test();

    start_test("alu");
    for (int k = 0; k < 8; k++) begin
      rnd = $random(seed);
      load_reg(3'(k), rnd[15:0]);
    end
    for (int n = 0; n < N_ALU; n++) begin
      rnd = $random(seed);
      case (rnd[10:8])
        3'd0, 3'd6: op = OP_ADD;
        3'd1, 3'd7: op = OP_SUB;
        3'd2:       op = OP_ADD | OP_IMM;
        3'd3:       op = OP_SUB | OP_IMM;
        3'd4:       op = OP_CMP;
        default:    op = OP_CMP | OP_IMM;
      endcase
      if (op[4]) issue(imm_form(op, rnd[2:0], rnd[23:16]), "alu_imm");
      else       issue(reg_form(op, rnd[2:0], rnd[5:3]), "alu_reg");
    end
    end_test();

    // fill every word so later loads never hit an unknown cell
    start_test("memory");
    for (int a = 0; a < 256; a++) begin
      rnd = $random(seed);
      issue(imm_form(OP_MV | OP_IMM, 3'd1, 8'(a)), "mvi_addr");
      load_reg(3'd2, rnd[15:0]);
      issue(reg_form(OP_ST, 3'd2, 3'd1), "st");
      issue(reg_form(OP_LD, 3'd3, 3'd1), "ld_after_st");
    end
    for (int n = 0; n < N_RAND_ST; n++) begin
      rnd = $random(seed);
      st_addr[n] = rnd[23:16];
      issue(imm_form(OP_MV | OP_IMM, 3'd5, rnd[23:16]), "mvi_addr");
      load_reg(3'd6, rnd[15:0]);
      issue(reg_form(OP_ST, 3'd6, 3'd5), "st");
    end
    for (int n = 0; n < N_RAND_ST; n++) begin
      issue(imm_form(OP_MV | OP_IMM, 3'd1, st_addr[n]), "mvi_addr");
      issue(reg_form(OP_LD, 3'd4, 3'd1), "ld");
    end
    end_test();

    start_test("forward");
    prev_dst = 3'd2;
    for (int n = 0; n < N_FWD; n++) begin
      rnd = $random(seed);
      rx  = rnd[2:0];
      ry  = rnd[5:3];
      if (rnd[7:6] != 2'd1) rx = prev_dst; // raw on rx
      if (rnd[7:6] != 2'd0) ry = prev_dst; // raw on ry
      case (rnd[10:8])
        3'd0:    op = OP_ADD;
        3'd1:    op = OP_SUB;
        3'd2:    op = OP_ADD | OP_IMM;
        3'd3:    op = OP_MV;
        3'd4:    op = OP_LD;
        3'd5:    op = OP_ST;
        3'd6:    op = OP_MVHI;
        default: op = OP_CMP;
      endcase
      if (op[4]) issue(imm_form(op, rx, rnd[23:16]), "fwd_imm");
      else       issue(reg_form(op, rx, ry), "fwd_reg");
      // read the stored word straight back, so st data and address show up
      if (op == OP_ST) issue(reg_form(OP_LD, rx, ry), "fwd_ld_back");
      if (op != OP_CMP) prev_dst = rx;
    end
    end_test();

    start_test("mvhi_nop");
    prev_dst = 3'd0;
    for (int n = 0; n < N_MIX; n++) begin
      rnd = $random(seed);
      if (rnd[0]) issue(NOP_WORD, "nop");  // dependency crosses the bubble
      rx = rnd[5] ? prev_dst : rnd[4:2];
      case (rnd[7:6])
        2'd0:    issue(imm_form(OP_MVHI, rx, rnd[15:8]), "mvhi");
        2'd1:    issue(imm_form(OP_ADD | OP_IMM, rx, rnd[15:8]), "addi");
        2'd2:    issue(reg_form(OP_ADD, rx, prev_dst), "add");
        default: issue(reg_form(OP_MV, rx, prev_dst), "mv");
      endcase
      prev_dst = rx;
    end
    end_test();

    $display("summary: %0d tests, %0d checks, %0d failed", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/cpu_pkg.sv
logic/cpu_execute_control.sv
logic/cpu_forward_detect.sv
logic/cpu_alu.sv
logic/cpu_data_ram.sv
logic/cpu_regfile.sv
logic/cpu_execute_datapath.sv
logic/cpu_execute_top.sv
test/tb_cpu_execute.sv
